/* src/macPkg.sv */
/*
  Shared types of the memory access controller front end
  Request, grant and dispatch layouts, address map and write channel states
*/
package macPkg;

  localparam int AddrW = 32;
  localparam int TagW  = 4;
  localparam int IdW   = 3;
  localparam int LenW  = 2;
  localparam int QosW  = 4;

  localparam int RowW  = 11;
  localparam int BankW = 2;
  localparam int ColW  = 8;
  localparam int WayW  = 3;   // Eight ways per row

  // Lowest address bit of each SDRAM field
  localparam int ColLsb  = 2;
  localparam int BankLsb = 10;
  localparam int RowLsb  = 12;

  typedef logic [AddrW-1:0] macAddr;
  typedef logic [TagW-1:0]  macTag;
  typedef logic [IdW-1:0]   macId;
  typedef logic [LenW-1:0]  macLen;
  typedef logic [QosW-1:0]  macQos;
  typedef logic [RowW-1:0]  macRow;
  typedef logic [BankW-1:0] macBank;
  typedef logic [ColW-1:0]  macCol;
  typedef logic [WayW-1:0]  macWay;

  typedef struct packed {
    macAddr addr;
    macTag  tag;
    macId   id;
    macLen  len;
    macQos  qos;
  } macReq;   // 45 bits

  typedef struct packed {
    macReq req;
    logic  isLoad;   // 1 for read queue, 0 for write queue
  } macGrant;

  typedef struct packed {
    macBank bank;
    macRow  row;
    macCol  col;
    macLen  size;
    macTag  tag;
    macId   id;
    logic   isLoad;
    macWay  way;
  } macDispatch;

  typedef enum logic [1:0] {Idle, Fetch, Burst, Last} wrState;

endpackage

/* src/writeChannel.sv */
/*
  Write request channel
  Takes one request, pushes it to the write queue and absorbs its data beats
*/
module writeChannel (
  input  logic          clk,
  input  logic          resetn,
  input  logic          validWr,
  input  macPkg::macReq reqWr,
  input  logic          eodWr,
  input  logic          queueFull,
  output logic          readyWr,
  output logic          push,
  output macPkg::macReq pushReq
);

  macPkg::wrState state;
  macPkg::wrState nextState;
  logic           accept;

  assign readyWr = (state == macPkg::Idle) && !queueFull;   // Low for the whole burst
  assign accept  = validWr && readyWr;
  assign push    = (state == macPkg::Fetch);

  always_comb begin
    nextState = state;
    case (state)
      macPkg::Idle: begin
        if (accept) begin
          nextState = macPkg::Fetch;
        end
      end
      macPkg::Fetch,
      macPkg::Burst: begin
        // The first beat may already carry the end strobe
        if (eodWr) begin
          nextState = macPkg::Last;
        end else begin
          nextState = macPkg::Burst;
        end
      end
      macPkg::Last: begin
        nextState = macPkg::Idle;
      end
      default: begin
        nextState = macPkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= macPkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pushReq <= reqWr;   // Held until the push in Fetch
    end
  end

endmodule

/* src/requestQueue.sv */
/*
  First-word-fall-through request FIFO
  Head entry is visible whenever the queue holds at least one request
*/
module requestQueue #(
  parameter int queueAddrW = 5
) (
  input  logic          clk,
  input  logic          resetn,
  input  logic          push,
  input  macPkg::macReq pushReq,
  input  logic          pop,
  output macPkg::macReq headReq,
  output logic          empty,
  output logic          full
);

  localparam int Depth = 1 << queueAddrW;

  macPkg::macReq       mem [Depth];
  logic [queueAddrW:0] wrPtr;   // Extra bit tells full from empty
  logic [queueAddrW:0] rdPtr;
  logic                doPush;
  logic                doPop;

  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[queueAddrW] != rdPtr[queueAddrW]) &&
                 (wrPtr[queueAddrW-1:0] == rdPtr[queueAddrW-1:0]);

  assign doPush = push && !full;   // Push on a full queue is dropped
  assign doPop  = pop && !empty;

  assign headReq = mem[rdPtr[queueAddrW-1:0]];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr[queueAddrW-1:0]] <= pushReq;
    end
  end

endmodule

/* src/queueArbiter.sv */
/*
  Round-robin arbiter between the write and read request queues
  Pops one head per cycle and drives it onto the shared dispatch bus
*/
module queueArbiter (
  input  logic            clk,
  input  logic            resetn,
  input  logic            wrEmpty,
  input  macPkg::macReq   wrHead,
  input  logic            rdEmpty,
  input  macPkg::macReq   rdHead,
  output logic            wrPop,
  output logic            rdPop,
  output logic            grantValid,
  output macPkg::macGrant grant
);

  logic lastRd;   // Read queue was served last

  // Write side wins when it is alone or when the read side went last
  assign wrPop = !wrEmpty && (rdEmpty || lastRd);
  assign rdPop = !rdEmpty && !wrPop;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      lastRd     <= 1'b0;
      grantValid <= 1'b0;
    end else begin
      grantValid <= wrPop || rdPop;
      if (wrPop) begin
        lastRd <= 1'b0;
      end else if (rdPop) begin
        lastRd <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrPop) begin
      grant.req    <= wrHead;
      grant.isLoad <= 1'b0;   // Store
    end else if (rdPop) begin
      grant.req    <= rdHead;
      grant.isLoad <= 1'b1;   // Load
    end
  end

endmodule

/* src/reorderProcessor.sv */
/*
  Reorder processor
  Decodes bank, row and column and assigns the per-row way index
*/
module reorderProcessor (
  input  logic               clk,
  input  logic               resetn,
  input  logic               grantValid,
  input  macPkg::macGrant    grant,
  output logic               dispatchValid,
  output macPkg::macDispatch dispatchItem
);

  localparam int KeyW   = macPkg::BankW + macPkg::RowW;
  localparam int TableN = 1 << KeyW;

  macPkg::macWay      wayTable [TableN];
  logic [TableN-1:0]  wayKnown;   // Entry written since reset
  macPkg::macBank     bank;
  macPkg::macRow      row;
  macPkg::macCol      col;
  logic [KeyW-1:0]    key;
  logic [KeyW-1:0]    s1Key;
  macPkg::macWay      readWay;
  macPkg::macWay      nextWay;
  logic               s1Valid;
  macPkg::macDispatch s1Item;

  assign bank = grant.req.addr[macPkg::BankLsb +: macPkg::BankW];
  assign row  = grant.req.addr[macPkg::RowLsb +: macPkg::RowW];
  assign col  = grant.req.addr[macPkg::ColLsb +: macPkg::ColW];
  assign key  = {bank, row};

  assign s1Key   = {s1Item.bank, s1Item.row};
  assign nextWay = s1Item.way + 3'd1;   // Wraps 7 to 0

  always_comb begin
    if (s1Valid && (s1Key == key)) begin
      // Same row still in flight, table write lands this edge
      readWay = nextWay;
    end else if (wayKnown[key]) begin
      readWay = wayTable[key];
    end else begin
      readWay = '0;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      s1Valid       <= 1'b0;
      dispatchValid <= 1'b0;
      wayKnown      <= '0;
    end else begin
      s1Valid       <= grantValid;
      dispatchValid <= s1Valid;
      if (s1Valid) begin
        wayKnown[s1Key] <= 1'b1;
      end
    end
  end

  // Stage one captures the decoded item
  always_ff @(posedge clk) begin
    s1Item.bank   <= bank;
    s1Item.row    <= row;
    s1Item.col    <= col;
    s1Item.size   <= grant.req.len;
    s1Item.tag    <= grant.req.tag;
    s1Item.id     <= grant.req.id;
    s1Item.isLoad <= grant.isLoad;
    s1Item.way    <= readWay;
  end

  // Stage two registers the output and writes back the next way
  always_ff @(posedge clk) begin
    dispatchItem <= s1Item;
    if (s1Valid) begin
      wayTable[s1Key] <= nextWay;
    end
  end

endmodule

/* src/memAccessController.sv */
/*
  Memory access controller request front end
  Write and read channels, request queues, arbiter and reorder processor
*/
module memAccessController #(
  parameter int queueAddrW = 5
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               validWr,
  input  macPkg::macReq      reqWr,
  input  logic               eodWr,
  output logic               readyWr,
  input  logic               validRd,
  input  macPkg::macReq      reqRd,
  output logic               readyRd,
  output logic               dispatchValid,
  output macPkg::macDispatch dispatchItem
);

  logic            wrPush;
  macPkg::macReq   wrPushReq;
  macPkg::macReq   wrHead;
  logic            wrEmpty;
  logic            wrFull;
  logic            wrPop;
  macPkg::macReq   rdHead;
  logic            rdEmpty;
  logic            rdFull;
  logic            rdPop;
  logic            grantValid;
  macPkg::macGrant grant;

  assign readyRd = ~rdFull;

  writeChannel wrChannel (
    .clk       (clk),
    .resetn    (resetn),
    .validWr   (validWr),
    .reqWr     (reqWr),
    .eodWr     (eodWr),
    .queueFull (wrFull),
    .readyWr   (readyWr),
    .push      (wrPush),
    .pushReq   (wrPushReq)
  );

  requestQueue #(.queueAddrW(queueAddrW)) wrQueue (
    .clk     (clk),
    .resetn  (resetn),
    .push    (wrPush),
    .pushReq (wrPushReq),
    .pop     (wrPop),
    .headReq (wrHead),
    .empty   (wrEmpty),
    .full    (wrFull)
  );

  // Read channel pushes straight in, the queue drops it when full
  requestQueue #(.queueAddrW(queueAddrW)) rdQueue (
    .clk     (clk),
    .resetn  (resetn),
    .push    (validRd),
    .pushReq (reqRd),
    .pop     (rdPop),
    .headReq (rdHead),
    .empty   (rdEmpty),
    .full    (rdFull)
  );

  queueArbiter arbiter (
    .clk        (clk),
    .resetn     (resetn),
    .wrEmpty    (wrEmpty),
    .wrHead     (wrHead),
    .rdEmpty    (rdEmpty),
    .rdHead     (rdHead),
    .wrPop      (wrPop),
    .rdPop      (rdPop),
    .grantValid (grantValid),
    .grant      (grant)
  );

  reorderProcessor reorder (
    .clk           (clk),
    .resetn        (resetn),
    .grantValid    (grantValid),
    .grant         (grant),
    .dispatchValid (dispatchValid),
    .dispatchItem  (dispatchItem)
  );

endmodule

/* testbench/tbClock.sv */
/*
  Testbench clock and reset source
*/
module tbClock (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // Period of 10
  end

  initial begin
    resetn = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);   // Release away from the active edge
    resetn = 1'b1;
  end

endmodule

/* testbench/tbMac.sv */
/*
  Testbench of the memory access controller front end
  Table driven requests checked against a way counting reference model
*/
module tbMac;

  typedef struct packed {
    logic [2:0]     test;
    logic           isRd;
    macPkg::macAddr addr;
    macPkg::macTag  tag;
    logic [2:0]     beats;   // Data beats, request len is beats - 1
  } stimEntry;

  localparam int MaxBurst = 4;

  logic               clk;
  logic               resetn;
  logic               validWr;
  macPkg::macReq      reqWr;
  logic               eodWr;
  logic               readyWr;
  logic               validRd;
  macPkg::macReq      reqRd;
  logic               readyRd;
  logic               dispatchValid;
  macPkg::macDispatch dispatchItem;

  stimEntry           stim[$];
  macPkg::macDispatch expWr[$];
  macPkg::macDispatch expRd[$];
  macPkg::macWay      wayModel [8192];   // Next way per bank and row
  logic [31:0]        rngState = 32'd96;
  int                 errors = 0;
  int                 dispatchCount = 0;
  int                 passCount = 0;
  int                 failCount = 0;

  tbClock clkGen (.clk(clk), .resetn(resetn));

  memAccessController #(.queueAddrW(5)) dut0 (
    .clk           (clk),
    .resetn        (resetn),
    .validWr       (validWr),
    .reqWr         (reqWr),
    .eodWr         (eodWr),
    .readyWr       (readyWr),
    .validRd       (validRd),
    .reqRd         (reqRd),
    .readyRd       (readyRd),
    .dispatchValid (dispatchValid),
    .dispatchItem  (dispatchItem)
  );

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // Row 22..12, bank 11..10, column 9..2, the rest is filler
  function automatic macPkg::macAddr makeAddr(input logic [1:0] bank, input logic [10:0] row,
                                              input logic [7:0] col);
    return {9'h1a5, row, bank, col, 2'b11};
  endfunction

  function automatic macPkg::macReq makeReq(input stimEntry e, input int idx);
    macPkg::macReq req;
    req.addr = e.addr;
    req.tag  = e.tag;
    req.id   = 3'(idx);
    req.len  = 2'(int'(e.beats) - 1);
    req.qos  = 4'(idx);
    return req;
  endfunction

  function automatic macPkg::macDispatch expectItem(input stimEntry e, input macPkg::macReq req);
    macPkg::macDispatch d;
    logic [12:0]        key;
    d.bank   = e.addr[11:10];
    d.row    = e.addr[22:12];
    d.col    = e.addr[9:2];
    d.size   = req.len;
    d.tag    = e.tag;
    d.id     = req.id;
    d.isLoad = e.isRd;
    key           = {d.bank, d.row};
    d.way         = wayModel[key];   // Ways follow acceptance order
    wayModel[key] = wayModel[key] + 3'd1;   // Wraps after seven
    return d;
  endfunction

  task automatic addEntry(input int test, input logic isRd, input macPkg::macAddr addr,
                          input macPkg::macTag tag, input int beats);
    stimEntry e;
    e.test  = 3'(test);
    e.isRd  = isRd;
    e.addr  = addr;
    e.tag   = tag;
    e.beats = 3'(beats);
    stim.push_back(e);
  endtask

  task automatic buildTable();
    logic [31:0] r;
    int          k;
    addEntry(2, 1'b1, makeAddr(2'd2, 11'h155, 8'h3c), 4'h5, 3);
    addEntry(3, 1'b0, makeAddr(2'd1, 11'h2aa, 8'h81), 4'ha, MaxBurst);
    for (k = 0; k < 9; k++) begin
      addEntry(4, 1'b1, makeAddr(2'd3, 11'h077, 8'(k)), 4'(k), 1);
    end
    // Same row in bank 0, interleaved back to back with bank 3
    addEntry(4, 1'b1, makeAddr(2'd0, 11'h077, 8'h10), 4'h1, 1);
    addEntry(4, 1'b1, makeAddr(2'd3, 11'h077, 8'h11), 4'h2, 1);
    addEntry(4, 1'b1, makeAddr(2'd0, 11'h077, 8'h12), 4'h3, 2);
    for (k = 0; k < 24; k++) begin
      r = xorshift();
      addEntry(5, r[0], makeAddr(r[2:1], {9'h0, r[4:3]}, r[12:5]), r[16:13],
               1 + int'(r[18:17]));   // Four rows only so they repeat
    end
  endtask

  task automatic checkDispatch(input macPkg::macDispatch got, input macPkg::macDispatch want,
                               input string what);
    if (got !== want) begin
      $display("Mismatch at %0t: %s got %h (way %0d) expected %h (way %0d)",
               $time, what, got, got.way, want, want.way);
      errors++;
    end
  endtask

  task automatic checkReady(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic sendRead(input stimEntry e, input int idx);
    macPkg::macReq req;
    req = makeReq(e, idx);
    while (!readyRd) begin
      @(negedge clk);
    end
    validRd = 1'b1;
    reqRd   = req;
    expRd.push_back(expectItem(e, req));
    @(negedge clk);
    validRd = 1'b0;   // Next read may raise it again at once
  endtask

  task automatic sendWrite(input stimEntry e, input int idx);
    macPkg::macReq req;
    int            b;
    req = makeReq(e, idx);
    while (!readyWr) begin
      @(negedge clk);
    end
    validWr = 1'b1;
    reqWr   = req;
    expWr.push_back(expectItem(e, req));
    @(negedge clk);
    validWr = 1'b0;
    for (b = 0; b < int'(e.beats); b++) begin
      checkReady(readyWr, 1'b0, "readyWr during burst");
      eodWr = (b == int'(e.beats) - 1);
      @(negedge clk);
    end
    eodWr = 1'b0;
    checkReady(readyWr, 1'b0, "readyWr after last beat");
    @(negedge clk);
    checkReady(readyWr, 1'b1, "readyWr back in idle");
  endtask

  task automatic checkArrival();
    macPkg::macDispatch want;
    if ((dispatchItem.isLoad && expRd.size() == 0) ||
        (!dispatchItem.isLoad && expWr.size() == 0)) begin
      $display("Unexpected dispatch at time %0t with no matching request outstanding", $time);
      errors++;
    end else begin
      if (dispatchItem.isLoad) begin
        want = expRd.pop_front();
      end else begin
        want = expWr.pop_front();
      end
      checkDispatch(dispatchItem, want, want.isLoad ? "read dispatch" : "write dispatch");
    end
  endtask

  task automatic finishTest(input int num, input string name, input int errBefore,
                            input int countBefore, input int sent);
    if (dispatchCount - countBefore != sent) begin
      $display("Test %0d gave %0d dispatches for %0d requests",
               num, dispatchCount - countBefore, sent);
      errors++;
    end
    if (errors == errBefore) begin
      passCount++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      failCount++;
      $display("Test %0d %s: %0d errors", num, name, errors - errBefore);
    end
  endtask

  task automatic runTest(input int t, input string name);
    int errBefore;
    int countBefore;
    int sent;
    int i;
    errBefore   = errors;
    countBefore = dispatchCount;
    sent        = 0;
    for (i = 0; i < stim.size(); i++) begin
      if (int'(stim[i].test) == t) begin
        if (stim[i].isRd) begin
          sendRead(stim[i], i);
        end else begin
          sendWrite(stim[i], i);
        end
        sent++;
      end
    end
    while (expRd.size() != 0 || expWr.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);   // Window for a stray dispatch
    finishTest(t, name, errBefore, countBefore, sent);
  endtask

  task automatic checkIdle();
    int errBefore;
    int countBefore;
    errBefore   = errors;
    countBefore = dispatchCount;
    checkReady(readyWr, 1'b1, "readyWr after reset");
    checkReady(readyRd, 1'b1, "readyRd after reset");
    repeat (10) begin
      checkReady(dispatchValid, 1'b0, "dispatchValid while idle");
      @(negedge clk);
    end
    finishTest(1, "reset state", errBefore, countBefore, 0);
  endtask

  // Dispatch monitor, sampled mid-cycle
  initial begin
    forever begin
      @(negedge clk);
      if (resetn && dispatchValid) begin
        dispatchCount++;
        checkArrival();
      end
    end
  end

  initial begin
    int limit;
    @(posedge resetn);
    limit = stim.size() * (MaxBurst + 10) + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    validWr = 1'b0;
    reqWr   = '0;
    eodWr   = 1'b0;
    validRd = 1'b0;
    reqRd   = '0;
    foreach (wayModel[k]) begin
      wayModel[k] = '0;
    end
    buildTable();
    @(posedge resetn);
    @(negedge clk);
    checkIdle();
    runTest(2, "single read");
    runTest(3, "write burst");
    runTest(4, "way sequence");
    runTest(5, "random mix");
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/macPkg.sv
src/writeChannel.sv
src/requestQueue.sv
src/queueArbiter.sv
src/reorderProcessor.sv
src/memAccessController.sv
testbench/tbClock.sv
testbench/tbMac.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tbMac -f verilog.f -o simMac
./obj_dir/simMac > sim.log
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi
